// File: band_vector_doa.f
+incdir+verilog
verilog/doa_sample_pkg.sv
verilog/doa_result_pkg.sv
verilog/band_correlator.sv
verilog/band_record_fifo.sv
verilog/isqrt_iter.sv
verilog/eigen_solver_2x2.sv
verilog/band_vector_doa.sv
verif/band_vector_doa_sva.sv
verif/band_vector_doa_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= band_vector_doa_tb
SEED      ?= 25546
FILELIST  ?= band_vector_doa.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build, run, and pass only when the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/band_vector_doa_tb.sv
`timescale 1ns/1ps
`include "doa_consts.svh"

module band_vector_doa_tb;
    import doa_sample_pkg::*;
    import doa_result_pkg::*;

    localparam int BEATS = `VECTOR_LEN / `PARALLEL;      // beats per frame
    localparam int BAND_CH = `VECTOR_LEN / `BANDS;
    localparam int SOLVE = `ROOT_WIDTH + 4;             // cycles per eigen solve
    localparam int WATCHDOG_CYCLES = 5 * 2 * (BEATS + `BANDS * SOLVE) * 4;
    localparam int DRAIN_LIMIT = 3 * `BANDS * SOLVE;
    localparam int CONST_FRAME = 0;
    localparam int RAND_FRAME = 1;
    localparam int SAME_ANT = 2;

    typedef struct packed {
        dout_t     l1, l2, y1, y2, x;
        band_idx_t band;
    } result_t;

    logic      clk, rst_n, din_valid, new_acc;
    beat_t     din1_re, din1_im, din2_re, din2_im;
    dout_t     lamb1, lamb2, eigen1_y, eigen2_y, eigen_x;
    logic      dout_valid, dout_error, fifo_full;
    band_idx_t band_out;

    sample_t x1_re [`VECTOR_LEN];
    sample_t x1_im [`VECTOR_LEN];
    sample_t x2_re [`VECTOR_LEN];
    sample_t x2_im [`VECTOR_LEN];
    result_t expected[$];
    result_t got[$];
    int      errors, checks, drops, error_base, check_base;
    bit      full_seen;

    band_vector_doa band_vector_doa_inst (.*);

    bind band_vector_doa band_vector_doa_sva band_vector_doa_sva_inst (
        .clk(clk), .rst_n(rst_n), .dout_valid(dout_valid), .dout_error(dout_error),
        .lamb1(lamb1), .lamb2(lamb2), .band_out(band_out));

    always #2 clk = ~clk;

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (dout_valid)
                got.push_back({lamb1, lamb2, eigen1_y, eigen2_y, eigen_x, band_out});
            if (dout_error)
                drops++;
            if (fifo_full)
                full_seen = 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    task automatic check_dout(input string what, input dout_t value, input dout_t want);
        checks++;
        if (value !== want) begin
            $display("Fail %0t: %s is %0d, expected %0d", $time, what, value, want);
            errors++;
        end
    endtask

    task automatic check_band(input band_idx_t value, input band_idx_t want);
        checks++;
        if (value !== want) begin
            $display("Fail %0t: band_out is %0d, expected %0d", $time, value, want);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input bit seen, input bit want);
        checks++;
        if (seen !== want) begin
            $display("Fail %0t: %s is %0b, expected %0b", $time, what, seen, want);
            errors++;
        end
    endtask

    task automatic check_result(input result_t want);
        result_t r;
        r = got.pop_front();
        check_band(r.band, want.band);
        check_dout("lamb1", r.l1, want.l1);
        check_dout("lamb2", r.l2, want.l2);
        check_dout("eigen1_y", r.y1, want.y1);
        check_dout("eigen2_y", r.y2, want.y2);
        check_dout("eigen_x", r.x, want.x);
    endtask

    function automatic longint floor_sqrt(input longint v);
        longint lo, hi, mid;
        lo = 0;
        hi = longint'(1) << 31;     // above any root of a 60-bit value
        while (hi - lo > 1) begin
            mid = (lo + hi) / 2;
            if (mid * mid <= v)
                lo = mid;
            else
                hi = mid;
        end
        return lo;
    endfunction

    function automatic longint power(input int b, input bit ant2);
        longint re, im, sum;
        sum = 0;
        for (int ch = b * BAND_CH; ch < (b + 1) * BAND_CH; ch++) begin
            re = ant2 ? x2_re[ch] : x1_re[ch];
            im = ant2 ? x2_im[ch] : x1_im[ch];
            sum += re * re + im * im;
        end
        return sum;
    endfunction

    // reference: band terms, then the 2x2 hermitian eigen outputs
    function automatic result_t model_band(input int b);
        longint ar, ai, br, bi, r11, r22, cre, cim, root, l1, l2;
        r11 = power(b, 1'b0);
        r22 = power(b, 1'b1);
        cre = 0;
        cim = 0;
        for (int ch = b * BAND_CH; ch < (b + 1) * BAND_CH; ch++) begin
            ar = x1_re[ch];
            ai = x1_im[ch];
            br = x2_re[ch];
            bi = x2_im[ch];
            cre += ar * br + ai * bi;   // x1 * conj(x2)
            cim += ai * br - ar * bi;
        end
        root = floor_sqrt((r11 - r22) * (r11 - r22) + 4 * (cre * cre + cim * cim));
        l1 = (r11 + r22 + root) >>> 1;
        l2 = (r11 + r22 - root) >>> 1;
        return {dout_t'(l1), dout_t'(l2), dout_t'(l1 - r11), dout_t'(l2 - r11),
                dout_t'(cre), band_idx_t'(b)};
    endfunction

    task automatic fill_frame(input int mode);
        sample_t c [4];
        for (int ch = 0; ch < `VECTOR_LEN; ch++) begin
            if (mode != CONST_FRAME || ch == 0)
                for (int i = 0; i < 4; i++)
                    c[i] = sample_t'($urandom);
            x1_re[ch] = c[0];
            x1_im[ch] = c[1];
            x2_re[ch] = (mode == SAME_ANT) ? c[0] : c[2];
            x2_im[ch] = (mode == SAME_ANT) ? c[1] : c[3];
        end
    endtask

    task automatic expect_frame(input int nbands);
        for (int b = 0; b < nbands; b++)
            expected.push_back(model_band(b));
    endtask

    task automatic new_frame_pulse();
        @(negedge clk);
        new_acc = 1'b1;
        din_valid = 1'b0;
    endtask

    task automatic drive_beats(input int first, input int count);
        for (int k = first; k < first + count; k++) begin
            @(negedge clk);
            new_acc = 1'b0;
            din_valid = 1'b1;
            for (int i = 0; i < `PARALLEL; i++) begin
                din1_re[i] = x1_re[k * `PARALLEL + i];
                din1_im[i] = x1_im[k * `PARALLEL + i];
                din2_re[i] = x2_re[k * `PARALLEL + i];
                din2_im[i] = x2_im[k * `PARALLEL + i];
            end
        end
    endtask

    task automatic go_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            new_acc = 1'b0;
            din_valid = 1'b0;
        end
    endtask

    // every record ends as a result or a drop
    task automatic wait_for(input int n);
        int waited;
        waited = 0;
        while (got.size() + drops < n && waited < DRAIN_LIMIT) begin
            go_idle(1);
            waited++;
        end
        if (got.size() + drops < n) begin
            $display("no progress: %0d of %0d band records came out", got.size() + drops, n);
            errors++;
        end
        go_idle(SOLVE);     // room for a stray extra result
    endtask

    task automatic compare_all();
        foreach (expected[k]) begin
            if (got.size() == 0) begin
                $display("band record %0d of %0d gave no result", k, expected.size());
                errors++;
                return;
            end
            check_result(expected[k]);
        end
        if (got.size() != 0) begin
            $display("%0d results came out with no band record behind them", got.size());
            errors++;
        end
    endtask

    // with drops, each result must match a later record than the one before
    task automatic compare_in_order();
        int ptr, pick;
        ptr = 0;
        while (got.size() > 0) begin
            pick = -1;
            for (int k = expected.size() - 1; k >= ptr; k--)
                if (expected[k] == got[0])
                    pick = k;
            if (pick < 0)
                for (int k = expected.size() - 1; k >= ptr; k--)
                    if (expected[k].band == got[0].band)
                        pick = k;
            if (pick < 0) begin
                $display("a result for band %0d has no band record left to match", got[0].band);
                errors++;
                got.delete(0);
            end else begin
                check_result(expected[pick]);
                ptr = pick + 1;
            end
        end
    endtask

    task automatic start_test();
        expected.delete();
        got.delete();
        drops = 0;
        full_seen = 1'b0;
        error_base = errors;
        check_base = checks;
    endtask

    task automatic finish_test(input string name);
        $display("test %-16s %0d checks, %0d errors", name, checks - check_base,
                 errors - error_base);
    endtask

    task automatic run_one_frame(input int mode);
        new_frame_pulse();
        fill_frame(mode);
        expect_frame(`BANDS);
        drive_beats(0, BEATS);
        wait_for(expected.size());
        compare_all();
        check_flag("dout_error pulsed", drops != 0, 1'b0);
    endtask

    task automatic test_same_antennas();
        longint r;
        start_test();
        new_frame_pulse();
        fill_frame(SAME_ANT);
        for (int b = 0; b < `BANDS; b++) begin
            r = power(b, 1'b0);     // x2 = x1 makes r22 and r12 equal r11
            expected.push_back({dout_t'(2 * r), dout_t'(0), dout_t'(r), dout_t'(-r),
                                dout_t'(r), band_idx_t'(b)});
        end
        drive_beats(0, BEATS);
        wait_for(`BANDS);
        compare_all();
        check_flag("dout_error pulsed", drops != 0, 1'b0);
        finish_test("same antennas");
    endtask

    task automatic test_restart();
        start_test();
        new_frame_pulse();
        fill_frame(RAND_FRAME);
        expect_frame(2);
        drive_beats(0, 2 * (BEATS / `BANDS) + 2);   // third band left half done
        wait_for(2);
        run_one_frame(RAND_FRAME);
        finish_test("mid-frame restart");
    endtask

    task automatic test_overflow();
        start_test();
        new_frame_pulse();
        for (int f = 0; f < 3; f++) begin
            fill_frame(RAND_FRAME);
            expect_frame(`BANDS);
            drive_beats(0, BEATS);
        end
        wait_for(3 * `BANDS);
        check_flag("fifo_full seen", full_seen, 1'b1);
        check_flag("dout_error pulsed", drops != 0, 1'b1);
        check_flag("results plus drops is 12", got.size() + drops == 3 * `BANDS, 1'b1);
        compare_in_order();
        finish_test("fifo overflow");
    endtask

    initial begin
        void'($urandom(32'h63ca));
        clk = 1'b0;
        rst_n = 1'b0;
        din1_re = '0;
        din1_im = '0;
        din2_re = '0;
        din2_im = '0;
        din_valid = 1'b0;
        new_acc = 1'b0;
        errors = 0;
        checks = 0;
        drops = 0;
        full_seen = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test();
        run_one_frame(CONST_FRAME);
        finish_test("constant frame");
        start_test();
        run_one_frame(RAND_FRAME);
        finish_test("random frame");
        test_same_antennas();
        test_restart();
        test_overflow();

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: verif/band_vector_doa_sva.sv
`timescale 1ns/1ps
`include "doa_consts.svh"

module band_vector_doa_sva (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      dout_valid,
    input logic                      dout_error,
    input doa_result_pkg::dout_t     lamb1,
    input doa_result_pkg::dout_t     lamb2,
    input doa_sample_pkg::band_idx_t band_out
);
    import doa_result_pkg::*;

    // one reset edge is enough to clear the output strobes
    property quiet_in_reset;
        @(posedge clk) (!rst_n && $past(!rst_n)) |-> (!dout_valid && !dout_error);
    endproperty

    property ordered_eigenvalues;
        @(posedge clk) disable iff (!rst_n) dout_valid |-> (lamb1 >= lamb2);   // signed
    endproperty

    property band_in_range;
        @(posedge clk) disable iff (!rst_n) dout_valid |-> (band_out < `BANDS);
    endproperty

    // a solve lasts far longer than one cycle
    property single_cycle_valid;
        @(posedge clk) disable iff (!rst_n) dout_valid |=> !dout_valid;
    endproperty

    quiet_chk: assert property (quiet_in_reset) else $error("output strobe high in reset");
    order_chk: assert property (ordered_eigenvalues) else $error("lamb1 below lamb2");
    band_chk:  assert property (band_in_range) else $error("band_out out of range");
    pulse_chk: assert property (single_cycle_valid) else $error("dout_valid held two cycles");

endmodule

// File: verilog/band_vector_doa.sv
`timescale 1ns/1ps

module band_vector_doa (
    input  logic                      clk,
    input  logic                      rst_n,
    input  doa_sample_pkg::beat_t     din1_re,
    input  doa_sample_pkg::beat_t     din1_im,
    input  doa_sample_pkg::beat_t     din2_re,
    input  doa_sample_pkg::beat_t     din2_im,
    input  logic                      din_valid,
    input  logic                      new_acc,    // one cycle ahead of a frame
    output doa_result_pkg::dout_t     lamb1,
    output doa_result_pkg::dout_t     lamb2,
    output doa_result_pkg::dout_t     eigen1_y,
    output doa_result_pkg::dout_t     eigen2_y,
    output doa_result_pkg::dout_t     eigen_x,
    output logic                      dout_valid,
    output logic                      dout_error,
    output doa_sample_pkg::band_idx_t band_out,
    output logic                      fifo_full
);
    import doa_result_pkg::*;

    band_rec_t rec, head;
    logic      rec_valid, fifo_empty, pop, start, root_done;
    disc_t     radicand;
    root_t     root;

    band_correlator band_correlator_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .din1_re   (din1_re),
        .din1_im   (din1_im),
        .din2_re   (din2_re),
        .din2_im   (din2_im),
        .din_valid (din_valid),
        .new_acc   (new_acc),
        .rec       (rec),
        .rec_valid (rec_valid)
    );

    band_record_fifo band_record_fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .rec   (rec),
        .push  (rec_valid),
        .pop   (pop),
        .head  (head),
        .empty (fifo_empty),
        .full  (fifo_full),
        .drop  (dout_error)     // record lost on a full buffer
    );

    isqrt_iter isqrt_iter_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .radicand (radicand),
        .root     (root),
        .done     (root_done)
    );

    eigen_solver_2x2 eigen_solver_2x2_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .head       (head),
        .empty      (fifo_empty),
        .root       (root),
        .root_done  (root_done),
        .pop        (pop),
        .radicand   (radicand),
        .start      (start),
        .lamb1      (lamb1),
        .lamb2      (lamb2),
        .eigen1_y   (eigen1_y),
        .eigen2_y   (eigen2_y),
        .eigen_x    (eigen_x),
        .band_out   (band_out),
        .dout_valid (dout_valid)
    );

endmodule

// File: verilog/eigen_solver_2x2.sv
`timescale 1ns/1ps
`include "doa_consts.svh"

module eigen_solver_2x2 (
    input  logic                      clk,
    input  logic                      rst_n,
    input  doa_result_pkg::band_rec_t head,
    input  logic                      empty,
    input  doa_result_pkg::root_t     root,
    input  logic                      root_done,
    output logic                      pop,
    output doa_result_pkg::disc_t     radicand,
    output logic                      start,
    output doa_result_pkg::dout_t     lamb1,
    output doa_result_pkg::dout_t     lamb2,
    output doa_result_pkg::dout_t     eigen1_y,
    output doa_result_pkg::dout_t     eigen2_y,
    output doa_result_pkg::dout_t     eigen_x,
    output doa_sample_pkg::band_idx_t band_out,
    output logic                      dout_valid
);
    import doa_result_pkg::*;

    typedef enum logic [1:0] {IDLE, LOAD, ROOT_WAIT, FINISH} state_t;

    state_t                       state;
    band_rec_t                    rec_r;
    logic signed [`ACC_WIDTH:0]   diff;
    logic signed [`DISC_WIDTH-1:0] diff_w, re_w, im_w, disc_s;
    dout_t                        trace, trace_r, root_ext, r11_ext, lamb1_n, lamb2_n;

    assign pop = (state == IDLE) && !empty;

    always_comb begin
        diff     = rec_r.r11 - rec_r.r22;
        diff_w   = diff;
        re_w     = rec_r.r12_re;
        im_w     = rec_r.r12_im;
        disc_s   = diff_w * diff_w + ((re_w * re_w + im_w * im_w) <<< 2);
        trace    = dout_t'(rec_r.r11) + dout_t'(rec_r.r22);
        root_ext = dout_t'(root);       // unsigned, zero extended
        r11_ext  = dout_t'(rec_r.r11);
        lamb1_n  = (trace_r + root_ext) >>> 1;
        lamb2_n  = (trace_r - root_ext) >>> 1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            start      <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            start      <= 1'b0;
            dout_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (!empty)
                        state <= LOAD;
                end
                LOAD: begin
                    start <= 1'b1;
                    state <= ROOT_WAIT;
                end
                ROOT_WAIT: begin
                    if (root_done) begin
                        dout_valid <= 1'b1;
                        state      <= FINISH;
                    end
                end
                FINISH:  state <= IDLE;     // outputs valid here
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            rec_r <= head;
        if (state == LOAD) begin
            radicand <= disc_t'(disc_s);
            trace_r  <= trace;
        end
        if (state == ROOT_WAIT && root_done) begin
            lamb1    <= lamb1_n;
            lamb2    <= lamb2_n;
            eigen1_y <= lamb1_n - r11_ext;
            eigen2_y <= lamb2_n - r11_ext;
            eigen_x  <= dout_t'(rec_r.r12_re);   // arctan takes y over x downstream
            band_out <= rec_r.band;
        end
    end

endmodule

// File: verilog/isqrt_iter.sv
`timescale 1ns/1ps
`include "doa_consts.svh"

module isqrt_iter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  doa_result_pkg::disc_t radicand,
    output doa_result_pkg::root_t root,
    output logic                  done
);
    import doa_result_pkg::*;

    localparam int CNT_W = $clog2(`ROOT_WIDTH);

    logic [`ROOT_WIDTH-1:0] rem_r, rem_src;
    logic [`ROOT_WIDTH+1:0] rem_sh, trial, rem_nxt;
    root_t                  root_src, root_nxt;
    disc_t                  rad_r, rad_src;
    logic [CNT_W-1:0]       cnt;
    logic                   busy;

    // one restoring step, the first one runs on the start cycle itself
    always_comb begin
        rem_src  = start ? '0 : rem_r;
        root_src = start ? '0 : root;
        rad_src  = start ? radicand : rad_r;
        rem_sh   = {rem_src, rad_src[`DISC_WIDTH-1 -: 2]};  // bring down next bit pair
        trial    = {root_src, 2'b01};                       // 4*root + 1
        if (rem_sh >= trial) begin
            rem_nxt  = rem_sh - trial;
            root_nxt = {root_src[`ROOT_WIDTH-2:0], 1'b1};
        end else begin
            rem_nxt  = rem_sh;
            root_nxt = {root_src[`ROOT_WIDTH-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`ROOT_WIDTH - 1);   // steps still to go
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // remainder stays below 2*root+1 so the top bits only matter on the last step
    always_ff @(posedge clk) begin
        if (start || busy) begin
            rem_r <= rem_nxt[`ROOT_WIDTH-1:0];
            root  <= root_nxt;
            rad_r <= rad_src << 2;
        end
    end

endmodule

// File: verilog/band_record_fifo.sv
`timescale 1ns/1ps
`include "doa_consts.svh"

module band_record_fifo (
    input  logic                      clk,
    input  logic                      rst_n,
    input  doa_result_pkg::band_rec_t rec,
    input  logic                      push,
    input  logic                      pop,
    output doa_result_pkg::band_rec_t head,
    output logic                      empty,
    output logic                      full,
    output logic                      drop
);
    import doa_result_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    band_rec_t        mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push, do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == (PTR_W+1)'(`FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;     // a push while full is lost
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];       // fall-through read

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= rec;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drop   <= 1'b0;
        end else begin
            drop <= push && full;
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/band_correlator.sv
`timescale 1ns/1ps
`include "doa_consts.svh"

module band_correlator (
    input  logic                      clk,
    input  logic                      rst_n,
    input  doa_sample_pkg::beat_t     din1_re,
    input  doa_sample_pkg::beat_t     din1_im,
    input  doa_sample_pkg::beat_t     din2_re,
    input  doa_sample_pkg::beat_t     din2_im,
    input  logic                      din_valid,
    input  logic                      new_acc,
    output doa_result_pkg::band_rec_t rec,
    output logic                      rec_valid
);
    import doa_sample_pkg::*;
    import doa_result_pkg::*;

    localparam int BEATS_PER_BAND = `VECTOR_LEN / (`PARALLEL * `BANDS);
    localparam int BEAT_CNT_W = (BEATS_PER_BAND > 1) ? $clog2(BEATS_PER_BAND) : 1;

    logic [BEAT_CNT_W-1:0] beat_cnt;
    band_idx_t             band_cnt;
    acc_t                  acc_r11, acc_r22, acc_re, acc_im;
    acc_t                  beat_r11, beat_r22, beat_re, beat_im;
    logic                  last_beat;

    // sum of the lane products of the current beat
    always_comb begin
        sample_t a, b, c, d;
        beat_r11 = '0;
        beat_r22 = '0;
        beat_re  = '0;
        beat_im  = '0;
        for (int i = 0; i < `PARALLEL; i++) begin
            a = din1_re[i];
            b = din1_im[i];
            c = din2_re[i];
            d = din2_im[i];
            beat_r11 = beat_r11 + a * a + b * b;
            beat_r22 = beat_r22 + c * c + d * d;
            // (a+jb)(c-jd)
            beat_re  = beat_re + a * c + b * d;
            beat_im  = beat_im + b * c - a * d;
        end
    end

    assign last_beat = din_valid && (beat_cnt == BEAT_CNT_W'(BEATS_PER_BAND - 1));

    always_ff @(posedge clk) begin
        if (!rst_n || new_acc) begin    // restart drops any partial band
            beat_cnt  <= '0;
            band_cnt  <= '0;
            acc_r11   <= '0;
            acc_r22   <= '0;
            acc_re    <= '0;
            acc_im    <= '0;
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= last_beat;
            if (last_beat) begin
                beat_cnt <= '0;
                band_cnt <= (band_cnt == band_idx_t'(`BANDS - 1)) ? '0 : band_cnt + 1'b1;
                acc_r11  <= '0;
                acc_r22  <= '0;
                acc_re   <= '0;
                acc_im   <= '0;
            end else if (din_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
                acc_r11  <= acc_r11 + beat_r11;
                acc_r22  <= acc_r22 + beat_r22;
                acc_re   <= acc_re + beat_re;
                acc_im   <= acc_im + beat_im;
            end
        end
    end

    // band totals include the closing beat
    always_ff @(posedge clk) begin
        if (last_beat) begin
            rec.r11    <= acc_r11 + beat_r11;
            rec.r22    <= acc_r22 + beat_r22;
            rec.r12_re <= acc_re + beat_re;
            rec.r12_im <= acc_im + beat_im;
            rec.band   <= band_cnt;
        end
    end

endmodule

// File: verilog/doa_result_pkg.sv
`include "doa_consts.svh"

package doa_result_pkg;

    typedef logic signed [`ACC_WIDTH-1:0] acc_t;

    // correlation terms of one finished band
    typedef struct packed {
        acc_t r11;      // |x1|^2
        acc_t r22;      // |x2|^2
        acc_t r12_re;   // re of x1*conj(x2)
        acc_t r12_im;   // im of x1*conj(x2)
        doa_sample_pkg::band_idx_t band;
    } band_rec_t;

    typedef logic signed [`DOUT_WIDTH-1:0] dout_t;

    // (r11-r22)^2 + 4|r12|^2, never negative
    typedef logic [`DISC_WIDTH-1:0] disc_t;
    typedef logic [`ROOT_WIDTH-1:0] root_t;

endpackage

// File: verilog/doa_sample_pkg.sv
`include "doa_consts.svh"

package doa_sample_pkg;

    // one real or imaginary part of an fft channel
    typedef logic signed [`DIN_WIDTH-1:0] sample_t;

    // lane i holds channel i of the beat
    typedef sample_t [`PARALLEL-1:0] beat_t;

    typedef logic [$clog2(`BANDS)-1:0] band_idx_t;

endpackage

// File: verilog/doa_consts.svh
`ifndef DOA_CONSTS_SVH
`define DOA_CONSTS_SVH

// input samples
`define DIN_WIDTH   12
`define PARALLEL    2     // channels per beat
`define VECTOR_LEN  32    // fft channels per frame
`define BANDS       4     // 8 channels, 4 beats each

// correlation and eigen datapath
`define ACC_WIDTH   28
`define DISC_WIDTH  60    // twice ROOT_WIDTH
`define ROOT_WIDTH  30
`define DOUT_WIDTH  32

// band record buffer
`define FIFO_DEPTH  4

`endif
